// File: flist.f
cpuPkg.sv
fetchStage.sv
decodeStage.sv
registerFile.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
pipelineCpu.sv
tbCpu_chk.sv
tbCpu.sv

// File: Bender.yml
package:
  name: pipeline_cpu

sources:
  - cpuPkg.sv
  - fetchStage.sv
  - decodeStage.sv
  - registerFile.sv
  - hazardUnit.sv
  - executeStage.sv
  - memoryStage.sv
  - pipelineCpu.sv
  - target: test
    files:
      - tbCpu_chk.sv
      - tbCpu.sv

// File: tbCpu.sv
`timescale 1ns/1ps

module tbCpu;

	localparam int clkPeriod      = 40;
	localparam int programInstr   = 2 * 15 + 2 * 10 + 10 + 8; // arith and load-use run twice
	localparam int watchdogCycles = 4 * 40 * programInstr;

	logic          clk = 1'b0;
	logic          reset;
	cpuPkg::instrT instr;
	cpuPkg::wordT  wbDatI;
	logic          wbAck;
	cpuPkg::wordT  instrAddr;
	logic          wbCyc;
	logic          wbStb;
	logic          wbWe;
	cpuPkg::wordT  wbAdr;
	cpuPkg::wordT  wbDatO;

	cpuPkg::instrT rom [64];
	cpuPkg::wordT  dataMem [64];
	cpuPkg::instrT code [$];    // program of the current test
	cpuPkg::wordT  expAddr [$];
	cpuPkg::wordT  expData [$];
	cpuPkg::wordT  logAddr [$]; // writes seen by the slave
	cpuPkg::wordT  logData [$];
	logic [15:0]   lfsr = 16'd45528;
	bit            waitsOn;
	bit            slaveBusy;
	bit            slaveReset;
	int            waitLeft;

	pipelineCpu #(.resetPc('0)) DUT (.*);

	always #(clkPeriod / 2) clk = ~clk;

	// instruction rom, answers in the same cycle
	assign instr = $isunknown(instrAddr) ? '0 : rom[instrAddr[7:2]];

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] stepLfsr(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic cpuPkg::wordT fillWord(cpuPkg::wordT addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // every address bit matters
	endfunction

	function automatic cpuPkg::instrT rType(cpuPkg::functT fn, cpuPkg::regAddrT rd,
		cpuPkg::regAddrT rs, cpuPkg::regAddrT rt, logic [4:0] shamt);
		return {cpuPkg::opRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic cpuPkg::instrT iType(cpuPkg::opcodeT op, cpuPkg::regAddrT rt,
		cpuPkg::regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic stopWithError(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkAddr(input int idx, input cpuPkg::wordT got, input cpuPkg::wordT exp);
		if (got !== exp)
			stopWithError($sformatf("mismatch wbAdr of store %0d: got 0x%08h expected 0x%08h",
				idx, got, exp));
	endtask

	task automatic checkWord(input int idx, input cpuPkg::wordT got, input cpuPkg::wordT exp);
		if (got !== exp)
			stopWithError($sformatf("mismatch wbDatO of store %0d: got 0x%08h expected 0x%08h",
				idx, got, exp));
	endtask

	// wishbone classic slave, acts 1 ns after the edge
	always @(posedge clk)
	begin
		slaveReset = reset; // stable at the edge
		#1;
		if (slaveReset)
		begin
			wbAck     = 1'b0;
			slaveBusy = 1'b0;
		end
		else if (wbAck)
			wbAck = 1'b0; // taken by the master at this edge
		else if (wbStb)
		begin
			if (!slaveBusy)
			begin
				slaveBusy = 1'b1;
				waitLeft  = 0;
				if (waitsOn)
				begin
					lfsr     = stepLfsr(lfsr);
					waitLeft = lfsr[0];
					lfsr     = stepLfsr(lfsr);
					waitLeft = waitLeft * 2 + lfsr[0]; // 0 to 3 waits
				end
			end
			if (waitLeft == 0)
			begin
				if (wbWe)
				begin
					dataMem[wbAdr[7:2]] = wbDatO;
					logAddr.push_back(wbAdr);
					logData.push_back(wbDatO);
				end
				else
					wbDatI = dataMem[wbAdr[7:2]];
				wbAck     = 1'b1;
				slaveBusy = 1'b0;
			end
			else
				waitLeft--;
		end
	end

	task automatic newProgram();
		code.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic expectStore(input cpuPkg::wordT addr, input cpuPkg::wordT data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// third fetch of the halt word means the second copy has branched, all older work is done
	task automatic waitForHalt(input cpuPkg::wordT haltAddr);
		int           seen;
		cpuPkg::wordT prev;
		seen = 0;
		prev = ~haltAddr;
		while (seen < 3)
		begin
			@(posedge clk);
			#1;
			if (instrAddr == haltAddr && prev != haltAddr)
				seen++;
			prev = instrAddr;
		end
	endtask

	task automatic compareLog();
		if (logAddr.size() < expAddr.size())
			stopWithError($sformatf("missing store: expected %0d stores but saw %0d",
				expAddr.size(), logAddr.size()));
		if (logAddr.size() > expAddr.size())
			stopWithError($sformatf("extra store: expected %0d stores but saw %0d",
				expAddr.size(), logAddr.size()));
		foreach (expAddr[i])
		begin
			checkAddr(i, logAddr[i], expAddr[i]);
			checkWord(i, logData[i], expData[i]);
		end
	endtask

	task automatic runProgram(input bit useWaits);
		cpuPkg::wordT haltAddr;
		@(posedge clk);
		#1 reset = 1'b1;
		@(posedge clk); // core in reset from here
		#1;
		foreach (rom[i])
			rom[i] = (i < code.size()) ? code[i] : '0;
		foreach (dataMem[i])
			dataMem[i] = fillWord(i * 4);
		logAddr.delete();
		logData.delete();
		waitsOn = useWaits;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		haltAddr = (code.size() - 1) * 4;
		waitForHalt(haltAddr);
		compareLog();
	endtask

	// dependent chain, every result forwarded
	task automatic arithTest(input bit useWaits);
		cpuPkg::wordT r1, r2, r3, r4, r5, r6, r7, r8;
		newProgram();
		code.push_back(iType(cpuPkg::opAddi, 1, 0, -3));
		code.push_back(iType(cpuPkg::opAddi, 2, 1, 100));
		code.push_back(rType(cpuPkg::fnAdd, 3, 2, 1, 0));
		code.push_back(rType(cpuPkg::fnSub, 4, 3, 1, 0));
		code.push_back(rType(cpuPkg::fnAnd, 5, 4, 3, 0));
		code.push_back(rType(cpuPkg::fnOr, 6, 5, 1, 0));
		code.push_back(rType(cpuPkg::fnSlt, 7, 6, 5, 0));
		code.push_back(rType(cpuPkg::fnSll, 8, 0, 7, 4));
		code.push_back(iType(cpuPkg::opSw, 8, 8, 4)); // base and data both forwarded
		code.push_back(iType(cpuPkg::opSw, 3, 0, 0));
		code.push_back(iType(cpuPkg::opSw, 4, 0, 4));
		code.push_back(iType(cpuPkg::opSw, 5, 0, 8));
		code.push_back(iType(cpuPkg::opSw, 6, 0, 12));
		code.push_back(iType(cpuPkg::opSw, 7, 0, 16));
		code.push_back(iType(cpuPkg::opBeq, 0, 0, -1));
		r1 = -32'sd3;
		r2 = r1 + 100;
		r3 = r2 + r1;
		r4 = r3 - r1;
		r5 = r4 & r3;
		r6 = r5 | r1;
		r7 = ($signed(r6) < $signed(r5)) ? 32'd1 : 32'd0;
		r8 = r7 << 4;
		expectStore(r8 + 4, r8);
		expectStore(0, r3);
		expectStore(4, r4);
		expectStore(8, r5);
		expectStore(12, r6);
		expectStore(16, r7);
		runProgram(useWaits);
	endtask

	task automatic loadUseTest(input bit useWaits);
		cpuPkg::wordT r3, r4;
		newProgram();
		code.push_back(iType(cpuPkg::opAddi, 1, 0, 40));
		code.push_back(iType(cpuPkg::opLw, 2, 1, 8));
		code.push_back(rType(cpuPkg::fnAdd, 3, 2, 1, 0)); // needs the load, one bubble
		code.push_back(iType(cpuPkg::opSw, 3, 0, 0));
		code.push_back(iType(cpuPkg::opLw, 4, 0, 4));
		code.push_back(iType(cpuPkg::opSw, 4, 1, 4));     // load data straight to store
		code.push_back(iType(cpuPkg::opLw, 5, 0, 0));     // reads back the first store
		code.push_back(rType(cpuPkg::fnAdd, 6, 1, 5, 0));
		code.push_back(iType(cpuPkg::opSw, 6, 0, 8));
		code.push_back(iType(cpuPkg::opBeq, 0, 0, -1));
		r3 = fillWord(48) + 40;
		r4 = fillWord(4);
		expectStore(0, r3);
		expectStore(44, r4);
		expectStore(8, 40 + r3);
		runProgram(useWaits);
	endtask

	task automatic branchTest();
		newProgram();
		code.push_back(iType(cpuPkg::opAddi, 1, 0, 9));
		code.push_back(iType(cpuPkg::opAddi, 2, 0, 9));
		code.push_back(iType(cpuPkg::opAddi, 3, 0, 2));
		code.push_back(iType(cpuPkg::opBeq, 3, 1, 2)); // 9 vs 2, falls through
		code.push_back(iType(cpuPkg::opSw, 1, 0, 0));
		code.push_back(iType(cpuPkg::opBeq, 2, 1, 2)); // taken
		code.push_back(iType(cpuPkg::opSw, 3, 0, 4));  // squashed
		code.push_back(iType(cpuPkg::opSw, 3, 0, 8));  // squashed
		code.push_back(iType(cpuPkg::opSw, 2, 0, 12)); // target
		code.push_back(iType(cpuPkg::opBeq, 0, 0, -1));
		expectStore(0, 9);
		expectStore(12, 9);
		runProgram(1'b0);
	endtask

	task automatic zeroRegTest();
		newProgram();
		code.push_back(iType(cpuPkg::opAddi, 0, 0, 77)); // discarded
		code.push_back(iType(cpuPkg::opAddi, 2, 0, 33));
		code.push_back(rType(cpuPkg::fnAdd, 0, 2, 2, 0));
		code.push_back(iType(cpuPkg::opSw, 0, 0, 0));
		code.push_back(iType(cpuPkg::opSw, 2, 0, 4));
		code.push_back(iType(cpuPkg::opAddi, 3, 0, -8));
		code.push_back(iType(cpuPkg::opSw, 3, 0, 8));
		code.push_back(iType(cpuPkg::opBeq, 0, 0, -1));
		expectStore(0, 0);
		expectStore(4, 33);
		expectStore(8, -32'sd8);
		runProgram(1'b0);
	endtask

	initial
	begin
		#(watchdogCycles * clkPeriod);
		stopWithError("watchdog expired before the programs reached their halt loop");
	end

	initial
	begin
		wait (DUT.busCheck.failCount != 0);
		stopWithError("a bus protocol assertion failed");
	end

	initial
	begin
		reset  = 1'b1;
		wbAck  = 1'b0;
		wbDatI = '0;
		arithTest(1'b0);
		loadUseTest(1'b0);
		branchTest();
		zeroRegTest();
		arithTest(1'b1);  // same log expected under wait states
		loadUseTest(1'b1);
		if (DUT.busCheck.failCount == 0)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
			stopWithError("bus protocol assertions failed during the run");
	end

endmodule

// File: tbCpu_chk.sv
`timescale 1ns/1ps

module tbCpu_chk (
	input logic         clk,
	input logic         reset,
	input logic         wbCyc,
	input logic         wbStb,
	input logic         wbAck,
	input cpuPkg::wordT wbAdr,
	input cpuPkg::wordT wbDatO
);

	int failCount = 0; // watched by the testbench

	stbInCycle: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
		else
		begin
			$error("wbStb high without wbCyc");
			failCount++;
		end

	// waiting master keeps strobe, address and data
	holdWhileWaiting: assert property (@(posedge clk) disable iff (reset)
		(wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbDatO)))
		else
		begin
			$error("bus request changed before wbAck");
			failCount++;
		end

	idleAfterReset: assert property (@(posedge clk) reset |=> !wbCyc)
		else
		begin
			$error("wbCyc high in the cycle after reset");
			failCount++;
		end

endmodule

bind pipelineCpu tbCpu_chk busCheck (.*);

// File: pipelineCpu.sv
`timescale 1ns/1ps

module pipelineCpu #(
	parameter cpuPkg::wordT resetPc = '0
) (
	input  logic          clk,
	input  logic          reset,
	input  cpuPkg::instrT instr,
	input  cpuPkg::wordT  wbDatI,
	input  logic          wbAck,
	output cpuPkg::wordT  instrAddr,
	output logic          wbCyc,
	output logic          wbStb,
	output logic          wbWe,
	output cpuPkg::wordT  wbAdr,
	output cpuPkg::wordT  wbDatO
);

	cpuPkg::instrT   ifInstr;
	cpuPkg::wordT    ifPcPlus4;
	cpuPkg::regAddrT rsAddr, rtAddr, idRs, idRt, idDest, exDest, wbDest;
	cpuPkg::wordT    rsData, rtData, idA, idB, idImm, idPcPlus4;
	cpuPkg::aluOpT   idAluOp;
	logic [4:0]      idShamt;
	logic            idAluSrc, idRegWrite, idMemRead, idMemWrite, idBranch;
	cpuPkg::fwdSelT  fwdA, fwdB;
	logic            stall, freeze, branchTaken;
	cpuPkg::wordT    branchTarget, exAluOut, exStoreData, wbData;
	logic            exRegWrite, exMemRead, exMemWrite, wbRegWrite;

	fetchStage #(.resetPc(resetPc)) fetch (.*);

	decodeStage decode (.*);

	registerFile regFile (.*);

	hazardUnit hazard (.*);

	executeStage execute (.*);

	memoryStage memory (.*);

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::wordT    exAluOut,
	input  cpuPkg::wordT    exStoreData,
	input  cpuPkg::regAddrT exDest,
	input  logic            exRegWrite,
	input  logic            exMemRead,
	input  logic            exMemWrite,
	input  cpuPkg::wordT    wbDatI,
	input  logic            wbAck,
	output logic            wbCyc,
	output logic            wbStb,
	output logic            wbWe,
	output cpuPkg::wordT    wbAdr,
	output cpuPkg::wordT    wbDatO,
	output logic            freeze,
	output logic            wbRegWrite,
	output cpuPkg::regAddrT wbDest,
	output cpuPkg::wordT    wbData
);

	logic         memAccess;
	logic         acked;     // transfer finished on the last edge
	logic         wbIsLoad;
	cpuPkg::wordT wbAluOut;
	cpuPkg::wordT wbLoadData;

	assign memAccess = exMemRead || exMemWrite;
	assign wbStb     = memAccess && !acked; // drops for one cycle after each ack
	assign wbCyc     = wbStb;
	assign wbWe      = exMemWrite;
	assign wbAdr     = {exAluOut[31:2], 2'b00}; // word aligned
	assign wbDatO    = exStoreData;

	// hold everything until the access in memory completes
	assign freeze = memAccess && !(wbStb && wbAck);

	always_ff @(posedge clk)
	begin
		if (reset)
			acked <= 1'b0;
		else
			acked <= wbStb && wbAck;
	end

	// memory/writeback
	always_ff @(posedge clk)
	begin
		if (reset)
			wbRegWrite <= 1'b0;
		else if (!freeze)
			wbRegWrite <= exRegWrite;
	end

	always_ff @(posedge clk)
	begin
		if (!freeze)
		begin
			wbDest     <= exDest;
			wbIsLoad   <= exMemRead;
			wbAluOut   <= exAluOut;
			wbLoadData <= wbDatI; // only meaningful for lw
		end
	end

	assign wbData = wbIsLoad ? wbLoadData : wbAluOut;

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::wordT    idA,
	input  cpuPkg::wordT    idB,
	input  cpuPkg::wordT    idImm,
	input  cpuPkg::wordT    idPcPlus4,
	input  cpuPkg::regAddrT idDest,
	input  cpuPkg::aluOpT   idAluOp,
	input  logic [4:0]      idShamt,
	input  logic            idAluSrc,
	input  logic            idRegWrite,
	input  logic            idMemRead,
	input  logic            idMemWrite,
	input  logic            idBranch,
	input  cpuPkg::fwdSelT  fwdA,
	input  cpuPkg::fwdSelT  fwdB,
	input  cpuPkg::wordT    wbData,
	input  logic            freeze,
	output cpuPkg::wordT    exAluOut,
	output cpuPkg::wordT    exStoreData,
	output cpuPkg::regAddrT exDest,
	output logic            exRegWrite,
	output logic            exMemRead,
	output logic            exMemWrite,
	output logic            branchTaken,
	output cpuPkg::wordT    branchTarget
);

	cpuPkg::wordT opA;
	cpuPkg::wordT rtVal;
	cpuPkg::wordT opB;
	cpuPkg::wordT aluResult;

	function automatic cpuPkg::wordT fwdMux(cpuPkg::fwdSelT sel, cpuPkg::wordT regVal);
		case (sel)
			cpuPkg::fwdMem: return exAluOut; // previous alu result
			cpuPkg::fwdWb:  return wbData;
			default:        return regVal;
		endcase
	endfunction

	assign opA   = fwdMux(fwdA, idA);
	assign rtVal = fwdMux(fwdB, idB); // also the store data
	assign opB   = idAluSrc ? idImm : rtVal;

	always_comb
	begin
		case (idAluOp)
			cpuPkg::aluAdd: aluResult = opA + opB;
			cpuPkg::aluSub: aluResult = opA - opB;
			cpuPkg::aluAnd: aluResult = opA & opB;
			cpuPkg::aluOr:  aluResult = opA | opB;
			cpuPkg::aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			cpuPkg::aluSll: aluResult = opB << idShamt; // rt shifted, rs unused
			default:        aluResult = opA + opB;
		endcase
	end

	// beq decided here on forwarded values
	assign branchTaken  = idBranch && (opA == rtVal);
	assign branchTarget = idPcPlus4 + {idImm[29:0], 2'b00};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
		end
		else if (!freeze)
		begin
			exRegWrite <= idRegWrite;
			exMemRead  <= idMemRead;
			exMemWrite <= idMemWrite;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!freeze)
		begin
			exAluOut    <= aluResult;
			exStoreData <= rtVal;
			exDest      <= idDest;
		end
	end

endmodule

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  cpuPkg::regAddrT rsAddr,     // sources in decode
	input  cpuPkg::regAddrT rtAddr,
	input  cpuPkg::regAddrT idRs,       // sources in execute
	input  cpuPkg::regAddrT idRt,
	input  logic            idMemRead,
	input  cpuPkg::regAddrT idDest,
	input  logic            exRegWrite,
	input  cpuPkg::regAddrT exDest,
	input  logic            wbRegWrite,
	input  cpuPkg::regAddrT wbDest,
	output cpuPkg::fwdSelT  fwdA,
	output cpuPkg::fwdSelT  fwdB,
	output logic            stall
);

	// younger producer in memory wins over writeback
	function automatic cpuPkg::fwdSelT pickFwd(cpuPkg::regAddrT src);
		if (src == '0)
			return cpuPkg::fwdNone; // r0 never forwards
		if (exRegWrite && (exDest == src))
			return cpuPkg::fwdMem;
		if (wbRegWrite && (wbDest == src))
			return cpuPkg::fwdWb;
		return cpuPkg::fwdNone;
	endfunction

	assign fwdA = pickFwd(idRs);
	assign fwdB = pickFwd(idRt);

	// load in execute feeding decode, one bubble
	assign stall = idMemRead && (idDest != '0) &&
		((idDest == rsAddr) || (idDest == rtAddr));

endmodule

// File: registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic            clk,
	input  cpuPkg::regAddrT rsAddr,
	input  cpuPkg::regAddrT rtAddr,
	input  logic            wbRegWrite,
	input  cpuPkg::regAddrT wbDest,
	input  cpuPkg::wordT    wbData,
	output cpuPkg::wordT    rsData,
	output cpuPkg::wordT    rtData
);

	cpuPkg::wordT regs [cpuPkg::regCount];

	// r0 reads zero, same-cycle write bypassed
	assign rsData = (rsAddr == '0) ? '0 :
		(wbRegWrite && (wbDest == rsAddr)) ? wbData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		(wbRegWrite && (wbDest == rtAddr)) ? wbData : regs[rtAddr];

	always_ff @(posedge clk)
	begin
		if (wbRegWrite && (wbDest != '0))
			regs[wbDest] <= wbData; // r0 never written
	end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::instrT   ifInstr,
	input  cpuPkg::wordT    ifPcPlus4,
	input  logic            stall,
	input  logic            freeze,
	input  logic            branchTaken,
	input  cpuPkg::wordT    rsData,
	input  cpuPkg::wordT    rtData,
	output cpuPkg::regAddrT rsAddr,
	output cpuPkg::regAddrT rtAddr,
	output cpuPkg::regAddrT idRs,
	output cpuPkg::regAddrT idRt,
	output cpuPkg::regAddrT idDest,
	output cpuPkg::wordT    idA,
	output cpuPkg::wordT    idB,
	output cpuPkg::wordT    idImm,
	output cpuPkg::wordT    idPcPlus4,
	output cpuPkg::aluOpT   idAluOp,
	output logic [4:0]      idShamt,
	output logic            idAluSrc,
	output logic            idRegWrite,
	output logic            idMemRead,
	output logic            idMemWrite,
	output logic            idBranch
);

	cpuPkg::opcodeT  opcode;
	cpuPkg::functT   funct;
	cpuPkg::regAddrT rdAddr;
	cpuPkg::regAddrT dest;
	cpuPkg::wordT    imm;
	cpuPkg::aluOpT   aluOp;
	logic            aluSrc;
	logic            regWrite;
	logic            memRead;
	logic            memWrite;
	logic            branch;

	assign opcode = cpuPkg::opcodeT'(ifInstr[cpuPkg::opHi:cpuPkg::opLo]);
	assign funct  = cpuPkg::functT'(ifInstr[cpuPkg::functHi:cpuPkg::functLo]);
	assign rsAddr = ifInstr[cpuPkg::rsHi:cpuPkg::rsLo]; // straight to regfile
	assign rtAddr = ifInstr[cpuPkg::rtHi:cpuPkg::rtLo];
	assign rdAddr = ifInstr[cpuPkg::rdHi:cpuPkg::rdLo];
	assign imm    = {{16{ifInstr[cpuPkg::immHi]}}, ifInstr[cpuPkg::immHi:cpuPkg::immLo]};
	assign dest   = (opcode == cpuPkg::opRType) ? rdAddr : rtAddr;

	// main control
	always_comb
	begin
		aluOp    = cpuPkg::aluAdd;
		aluSrc   = 1'b0;
		regWrite = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		branch   = 1'b0;
		case (opcode)
			cpuPkg::opRType:
			begin
				regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr:  aluOp = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
					cpuPkg::fnSll: aluOp = cpuPkg::aluSll;
					default:       regWrite = 1'b0; // unknown funct, bubble
				endcase
			end
			cpuPkg::opAddi:
			begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			cpuPkg::opLw:
			begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				aluSrc   = 1'b1; // base plus offset
			end
			cpuPkg::opSw:
			begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			cpuPkg::opBeq: branch = 1'b1; // compared in execute
			default: ;                    // unknown opcode stays a bubble
		endcase
	end

	// decode/execute control, bubble on stall or flush
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			idRegWrite <= 1'b0;
			idMemRead  <= 1'b0;
			idMemWrite <= 1'b0;
			idBranch   <= 1'b0;
		end
		else if (!freeze)
		begin
			if (stall || branchTaken)
			begin
				idRegWrite <= 1'b0;
				idMemRead  <= 1'b0;
				idMemWrite <= 1'b0;
				idBranch   <= 1'b0;
			end
			else
			begin
				idRegWrite <= regWrite && (dest != '0); // r0 writes dropped here
				idMemRead  <= memRead;
				idMemWrite <= memWrite;
				idBranch   <= branch;
			end
		end
	end

	// payload, harmless under a bubble
	always_ff @(posedge clk)
	begin
		if (!freeze)
		begin
			idRs      <= rsAddr;
			idRt      <= rtAddr;
			idDest    <= dest;
			idA       <= rsData;
			idB       <= rtData;
			idImm     <= imm;
			idPcPlus4 <= ifPcPlus4;
			idAluOp   <= aluOp;
			idShamt   <= ifInstr[cpuPkg::shamtHi:cpuPkg::shamtLo];
			idAluSrc  <= aluSrc;
		end
	end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
	parameter cpuPkg::wordT resetPc = '0
) (
	input  logic          clk,
	input  logic          reset,
	input  cpuPkg::instrT instr,        // from rom, same cycle
	input  logic          stall,
	input  logic          freeze,
	input  logic          branchTaken,
	input  cpuPkg::wordT  branchTarget,
	output cpuPkg::wordT  instrAddr,
	output cpuPkg::instrT ifInstr,
	output cpuPkg::wordT  ifPcPlus4
);

	cpuPkg::wordT pc;
	cpuPkg::wordT pcPlus4;

	assign instrAddr = pc;
	assign pcPlus4   = pc + 32'd4; // sequential next pc

	// pc and fetch/decode instruction
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc      <= resetPc;
			ifInstr <= '0; // all zero word is a nop
		end
		else if (!freeze)
		begin
			if (branchTaken)
			begin
				pc      <= branchTarget;
				ifInstr <= '0; // squash the fetched one
			end
			else if (!stall)
			begin
				pc      <= pcPlus4;
				ifInstr <= instr;
			end
		end
	end

	// pc plus four of the fetched word, base of the branch target
	always_ff @(posedge clk)
	begin
		if (!freeze && !stall)
			ifPcPlus4 <= pcPlus4;
	end

endmodule

// File: cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;    // data word, register value or byte address
	typedef logic [31:0] instrT;   // raw instruction word
	typedef logic [4:0]  regAddrT; // register number

	localparam int regCount = 32;

	// primary opcodes, anything else decodes as a bubble
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// funct field of R-type
	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		aluAnd = 4'h0,
		aluOr  = 4'h1,
		aluAdd = 4'h2,
		aluSub = 4'h6,
		aluSlt = 4'h7,
		aluSll = 4'h8
	} aluOpT;

	// operand source in execute
	typedef enum logic [1:0] {
		fwdNone = 2'd0, // decode/execute register
		fwdMem  = 2'd1, // execute/memory alu result
		fwdWb   = 2'd2  // writeback value
	} fwdSelT;

	// instruction field positions
	localparam int opHi    = 31;
	localparam int opLo    = 26;
	localparam int rsHi    = 25;
	localparam int rsLo    = 21;
	localparam int rtHi    = 20;
	localparam int rtLo    = 16;
	localparam int rdHi    = 15;
	localparam int rdLo    = 11;
	localparam int shamtHi = 10;
	localparam int shamtLo = 6;
	localparam int functHi = 5;
	localparam int functLo = 0;
	localparam int immHi   = 15;
	localparam int immLo   = 0;

endpackage
